// File: Makefile
VERILATOR = verilator
TOP       = mem_issue_unit_tb
FILELIST  = filelist.f
VFLAGS    = --binary --timing --assert -j 0 --top-module $(TOP)
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	else \
		echo "simulation ok"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
logic/mem_issue_pkg.sv
logic/busy_table.sv
logic/memisq_ctrl.sv
logic/memisq_payload.sv
logic/memisq_wakeup.sv
logic/mem_issue_unit.sv
testbench/mem_issue_unit_sva.sv
testbench/mem_issue_unit_tb.sv

// File: logic/busy_table.sv
`timescale 1ns/1ps

module busy_table (
   input  logic                                clk,
   input  logic                                reset_n,
   input  logic                                instr0_enq_valid,
   input  logic                                instr1_enq_valid,
   input  mem_issue_pkg::prf_id_t              instr0_t,
   input  mem_issue_pkg::prf_id_t              instr1_t,
   input  mem_issue_pkg::prf_id_t              instr0_src1_id,
   input  mem_issue_pkg::prf_id_t              instr0_src2_id,
   input  mem_issue_pkg::prf_id_t              instr1_src1_id,
   input  mem_issue_pkg::prf_id_t              instr1_src2_id,
   input  logic [mem_issue_pkg::WB_PORTS-1:0]  wb_hit,
   input  mem_issue_pkg::prf_id_t              wb_prd [mem_issue_pkg::WB_PORTS],
   output logic                                instr0_src1_busy,
   output logic                                instr0_src2_busy,
   output logic                                instr1_src1_busy,
   output logic                                instr1_src2_busy
);
   import mem_issue_pkg::*;

   logic [2**PRF_WIDTH-1:0] busy;
   logic [2**PRF_WIDTH-1:0] wb_clr;   // registers written back this cycle

   always_comb begin
      wb_clr = '0;
      for (int p = 0; p < WB_PORTS; p++) begin
         if (wb_hit[p])
            wb_clr[wb_prd[p]] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         busy <= '0;
      end else begin
         busy <= busy & ~wb_clr;
         // new destinations win over a clear at the same edge
         if (instr0_enq_valid)
            busy[instr0_t] <= 1'b1;
         if (instr1_enq_valid)
            busy[instr1_t] <= 1'b1;
      end
   end

   // same-cycle writeback bypass
   assign instr0_src1_busy = busy[instr0_src1_id] & ~wb_clr[instr0_src1_id];
   assign instr0_src2_busy = busy[instr0_src2_id] & ~wb_clr[instr0_src2_id];

   // instr1 may read the destination of instr0 in the same group
   assign instr1_src1_busy = (busy[instr1_src1_id] & ~wb_clr[instr1_src1_id]) |
                             (instr0_enq_valid & (instr1_src1_id == instr0_t));
   assign instr1_src2_busy = (busy[instr1_src2_id] & ~wb_clr[instr1_src2_id]) |
                             (instr0_enq_valid & (instr1_src2_id == instr0_t));

endmodule

// File: logic/mem_issue_pkg.sv
package mem_issue_pkg;

   localparam int PRF_WIDTH = 6;   // 64 physical registers
   localparam int ROB_WIDTH = 5;   // robid carries one more bit for wrap
   localparam int WB_PORTS  = 4;

   typedef logic [PRF_WIDTH-1:0] prf_id_t;
   typedef logic [ROB_WIDTH:0]   rob_id_t;
   typedef logic [31:0]          pc_t;
   typedef logic [7:0]           mem_ctrl_t;
   typedef logic [1:0]           left_t;

   // bits 7 to 2 hold the memory opcode
   localparam int CTRL_RS1_VALID = 0;
   localparam int CTRL_RS2_VALID = 1;

   // free-slot codes seen by dispatch
   localparam left_t LEFT_NONE = 2'd0;
   localparam left_t LEFT_ONE  = 2'd1;
   localparam left_t LEFT_MORE = 2'd2;

endpackage

// File: logic/mem_issue_unit.sv
`timescale 1ns/1ps

module mem_issue_unit #(
   parameter int MEMISQ_DEPTH = 8
) (
   input  logic                       clk,
   input  logic                       reset_n,
   input  logic                       instr0_enq_valid,
   input  logic                       instr1_enq_valid,
   input  mem_issue_pkg::mem_ctrl_t   instr0_control,
   input  mem_issue_pkg::mem_ctrl_t   instr1_control,
   input  mem_issue_pkg::pc_t         instr0_pc,
   input  mem_issue_pkg::pc_t         instr1_pc,
   input  mem_issue_pkg::rob_id_t     instr0_robid,
   input  mem_issue_pkg::rob_id_t     instr1_robid,
   input  mem_issue_pkg::prf_id_t     instr0_src1_id,
   input  mem_issue_pkg::prf_id_t     instr0_src2_id,
   input  mem_issue_pkg::prf_id_t     instr1_src1_id,
   input  mem_issue_pkg::prf_id_t     instr1_src2_id,
   input  mem_issue_pkg::prf_id_t     instr0_t,
   input  mem_issue_pkg::prf_id_t     instr1_t,
   input  logic                       writeback0_valid,
   input  logic                       writeback0_need_to_wb,
   input  mem_issue_pkg::prf_id_t     writeback0_prd,
   input  logic                       writeback1_valid,
   input  logic                       writeback1_need_to_wb,
   input  mem_issue_pkg::prf_id_t     writeback1_prd,
   input  logic                       writeback2_valid,
   input  logic                       writeback2_need_to_wb,
   input  mem_issue_pkg::prf_id_t     writeback2_prd,
   input  logic                       writeback3_valid,
   input  logic                       writeback3_need_to_wb,
   input  mem_issue_pkg::prf_id_t     writeback3_prd,
   input  logic                       flush_valid,
   input  mem_issue_pkg::rob_id_t     flush_robid,
   input  logic                       mem_issue_stall,
   output mem_issue_pkg::left_t       memisq_left,
   output logic                       slot_valid,
   output mem_issue_pkg::prf_id_t     slot_t,
   output mem_issue_pkg::prf_id_t     slot_src1_id,
   output mem_issue_pkg::prf_id_t     slot_src2_id,
   output mem_issue_pkg::mem_ctrl_t   slot_control,
   output mem_issue_pkg::pc_t         slot_pc,
   output mem_issue_pkg::rob_id_t     slot_robid
);
   import mem_issue_pkg::*;

   localparam int IDX_W = $clog2(MEMISQ_DEPTH);

   logic [WB_PORTS-1:0]             wb_hit;
   prf_id_t                         wb_prd [WB_PORTS];
   logic                            i0_src1_busy, i0_src2_busy;
   logic                            i1_src1_busy, i1_src2_busy;
   logic                            alloc0_en, alloc1_en;
   logic [IDX_W-1:0]                alloc0_idx, alloc1_idx, issue_idx;
   logic [MEMISQ_DEPTH-1:0]         entry_valid, entry_ready;
   logic [MEMISQ_DEPTH*$bits(rob_id_t)-1:0] entry_robid;

   // a writeback counts only when it really writes a register
   assign wb_hit = {writeback3_valid & writeback3_need_to_wb,
                    writeback2_valid & writeback2_need_to_wb,
                    writeback1_valid & writeback1_need_to_wb,
                    writeback0_valid & writeback0_need_to_wb};
   assign wb_prd = '{writeback0_prd, writeback1_prd, writeback2_prd, writeback3_prd};

   busy_table i_busy_table (
      .clk, .reset_n, .instr0_enq_valid, .instr1_enq_valid, .instr0_t, .instr1_t,
      .instr0_src1_id, .instr0_src2_id, .instr1_src1_id, .instr1_src2_id,
      .wb_hit, .wb_prd,
      .instr0_src1_busy (i0_src1_busy), .instr0_src2_busy (i0_src2_busy),
      .instr1_src1_busy (i1_src1_busy), .instr1_src2_busy (i1_src2_busy)
   );

   memisq_ctrl #(.MEMISQ_DEPTH(MEMISQ_DEPTH)) i_memisq_ctrl (
      .clk, .reset_n, .instr0_enq_valid, .instr1_enq_valid, .flush_valid, .flush_robid,
      .mem_issue_stall, .entry_ready, .entry_robid, .alloc0_en, .alloc1_en,
      .alloc0_idx, .alloc1_idx, .issue_idx, .entry_valid,
      .clear_en (), .clear_mask (),   // flush clears stay inside the control
      .slot_valid, .memisq_left
   );

   memisq_payload #(.MEMISQ_DEPTH(MEMISQ_DEPTH)) i_memisq_payload (
      .clk, .reset_n, .alloc0_en, .alloc1_en, .alloc0_idx, .alloc1_idx,
      .instr0_pc, .instr1_pc, .instr0_robid, .instr1_robid,
      .instr0_control, .instr1_control, .instr0_src1_id, .instr0_src2_id,
      .instr1_src1_id, .instr1_src2_id, .instr0_t, .instr1_t, .issue_idx,
      .entry_robid, .slot_t, .slot_src1_id, .slot_src2_id, .slot_control,
      .slot_pc, .slot_robid
   );

   memisq_wakeup #(.MEMISQ_DEPTH(MEMISQ_DEPTH)) i_memisq_wakeup (
      .clk, .reset_n, .alloc0_en, .alloc1_en, .alloc0_idx, .alloc1_idx,
      .instr0_src1_id, .instr0_src2_id, .instr1_src1_id, .instr1_src2_id,
      .instr0_rs1_valid (instr0_control[CTRL_RS1_VALID]),
      .instr0_rs2_valid (instr0_control[CTRL_RS2_VALID]),
      .instr1_rs1_valid (instr1_control[CTRL_RS1_VALID]),
      .instr1_rs2_valid (instr1_control[CTRL_RS2_VALID]),
      .instr0_src1_busy (i0_src1_busy), .instr0_src2_busy (i0_src2_busy),
      .instr1_src1_busy (i1_src1_busy), .instr1_src2_busy (i1_src2_busy),
      .entry_valid, .wb_hit, .wb_prd, .entry_ready
   );

endmodule

// File: logic/memisq_ctrl.sv
`timescale 1ns/1ps

module memisq_ctrl #(
   parameter int MEMISQ_DEPTH = 8
) (
   input  logic                                 clk,
   input  logic                                 reset_n,
   input  logic                                 instr0_enq_valid,
   input  logic                                 instr1_enq_valid,
   input  logic                                 flush_valid,
   input  mem_issue_pkg::rob_id_t               flush_robid,
   input  logic                                 mem_issue_stall,
   input  logic [MEMISQ_DEPTH-1:0]              entry_ready,
   input  logic [MEMISQ_DEPTH*$bits(mem_issue_pkg::rob_id_t)-1:0] entry_robid,
   output logic                                 alloc0_en,
   output logic                                 alloc1_en,
   output logic [$clog2(MEMISQ_DEPTH)-1:0]      alloc0_idx,
   output logic [$clog2(MEMISQ_DEPTH)-1:0]      alloc1_idx,
   output logic [$clog2(MEMISQ_DEPTH)-1:0]      issue_idx,
   output logic [MEMISQ_DEPTH-1:0]              entry_valid,
   output logic                                 clear_en,
   output logic [MEMISQ_DEPTH-1:0]              clear_mask,
   output logic                                 slot_valid,
   output mem_issue_pkg::left_t                 memisq_left
);
   import mem_issue_pkg::*;

   localparam int IDX_W = $clog2(MEMISQ_DEPTH);
   localparam int RW    = $bits(rob_id_t);

   logic [IDX_W-1:0] head;
   logic [IDX_W-1:0] tail;   // oldest entry
   logic [IDX_W:0]   free_cnt;

   // head sits just past the last valid entry of the run
   always_comb begin
      head = tail;
      for (int i = 0; i < MEMISQ_DEPTH; i++) begin
         if (entry_valid[i] && !entry_valid[(i + 1) % MEMISQ_DEPTH])
            head = IDX_W'(i + 1);
      end
   end

   assign alloc0_en  = (instr0_enq_valid | instr1_enq_valid) & ~flush_valid;
   assign alloc1_en  = instr0_enq_valid & instr1_enq_valid & ~flush_valid;
   assign alloc0_idx = head;
   assign alloc1_idx = head + 1'b1;
   assign issue_idx  = tail;

   // younger than flush_robid, wrap bits flip the index compare
   always_comb begin
      rob_id_t r;
      for (int i = 0; i < MEMISQ_DEPTH; i++) begin
         r = entry_robid[i*RW +: RW];
         clear_mask[i] = entry_valid[i] &
                         ((r[ROB_WIDTH] ^ flush_robid[ROB_WIDTH]) ^
                          (r[ROB_WIDTH-1:0] > flush_robid[ROB_WIDTH-1:0]));
      end
   end

   assign clear_en = flush_valid;

   assign slot_valid = entry_valid[tail] & entry_ready[tail] & ~flush_valid &
                       ~mem_issue_stall;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         entry_valid <= '0;
         tail        <= '0;
      end else if (clear_en) begin
         entry_valid <= entry_valid & ~clear_mask;   // no enqueue or issue here
      end else begin
         if (alloc0_en)
            entry_valid[alloc0_idx] <= 1'b1;
         if (alloc1_en)
            entry_valid[alloc1_idx] <= 1'b1;
         if (slot_valid) begin
            entry_valid[tail] <= 1'b0;
            tail              <= tail + 1'b1;
         end
      end
   end

   always_comb begin
      free_cnt = '0;
      for (int i = 0; i < MEMISQ_DEPTH; i++)
         free_cnt = free_cnt + (IDX_W + 1)'(!entry_valid[i]);
      if (free_cnt > 1)
         memisq_left = LEFT_MORE;
      else if (free_cnt == 0)
         memisq_left = LEFT_NONE;
      else
         memisq_left = LEFT_ONE;
   end

endmodule

// File: logic/memisq_payload.sv
`timescale 1ns/1ps

module memisq_payload #(
   parameter int MEMISQ_DEPTH = 8
) (
   input  logic                                 clk,
   input  logic                                 reset_n,
   input  logic                                 alloc0_en,
   input  logic                                 alloc1_en,
   input  logic [$clog2(MEMISQ_DEPTH)-1:0]      alloc0_idx,
   input  logic [$clog2(MEMISQ_DEPTH)-1:0]      alloc1_idx,
   input  mem_issue_pkg::pc_t                   instr0_pc,
   input  mem_issue_pkg::pc_t                   instr1_pc,
   input  mem_issue_pkg::rob_id_t               instr0_robid,
   input  mem_issue_pkg::rob_id_t               instr1_robid,
   input  mem_issue_pkg::mem_ctrl_t             instr0_control,
   input  mem_issue_pkg::mem_ctrl_t             instr1_control,
   input  mem_issue_pkg::prf_id_t               instr0_src1_id,
   input  mem_issue_pkg::prf_id_t               instr0_src2_id,
   input  mem_issue_pkg::prf_id_t               instr1_src1_id,
   input  mem_issue_pkg::prf_id_t               instr1_src2_id,
   input  mem_issue_pkg::prf_id_t               instr0_t,
   input  mem_issue_pkg::prf_id_t               instr1_t,
   input  logic [$clog2(MEMISQ_DEPTH)-1:0]      issue_idx,
   output logic [MEMISQ_DEPTH*$bits(mem_issue_pkg::rob_id_t)-1:0] entry_robid,
   output mem_issue_pkg::prf_id_t               slot_t,
   output mem_issue_pkg::prf_id_t               slot_src1_id,
   output mem_issue_pkg::prf_id_t               slot_src2_id,
   output mem_issue_pkg::mem_ctrl_t             slot_control,
   output mem_issue_pkg::pc_t                   slot_pc,
   output mem_issue_pkg::rob_id_t               slot_robid
);
   import mem_issue_pkg::*;

   localparam int RW = $bits(rob_id_t);

   pc_t       pc_q    [MEMISQ_DEPTH];
   rob_id_t   robid_q [MEMISQ_DEPTH];
   mem_ctrl_t ctrl_q  [MEMISQ_DEPTH];
   prf_id_t   src1_q  [MEMISQ_DEPTH];
   prf_id_t   src2_q  [MEMISQ_DEPTH];
   prf_id_t   t_q     [MEMISQ_DEPTH];

   // a lone enqueue always arrives on instr1
   always_ff @(posedge clk) begin
      if (reset_n && alloc0_en) begin
         pc_q[alloc0_idx]    <= alloc1_en ? instr0_pc : instr1_pc;
         robid_q[alloc0_idx] <= alloc1_en ? instr0_robid : instr1_robid;
         ctrl_q[alloc0_idx]  <= alloc1_en ? instr0_control : instr1_control;
         src1_q[alloc0_idx]  <= alloc1_en ? instr0_src1_id : instr1_src1_id;
         src2_q[alloc0_idx]  <= alloc1_en ? instr0_src2_id : instr1_src2_id;
         t_q[alloc0_idx]     <= alloc1_en ? instr0_t : instr1_t;
      end
      if (reset_n && alloc1_en) begin
         pc_q[alloc1_idx]    <= instr1_pc;
         robid_q[alloc1_idx] <= instr1_robid;
         ctrl_q[alloc1_idx]  <= instr1_control;
         src1_q[alloc1_idx]  <= instr1_src1_id;
         src2_q[alloc1_idx]  <= instr1_src2_id;
         t_q[alloc1_idx]     <= instr1_t;
      end
   end

   always_comb begin
      for (int i = 0; i < MEMISQ_DEPTH; i++)
         entry_robid[i*RW +: RW] = robid_q[i];
   end

   assign slot_pc      = pc_q[issue_idx];
   assign slot_robid   = robid_q[issue_idx];
   assign slot_control = ctrl_q[issue_idx];
   assign slot_src1_id = src1_q[issue_idx];
   assign slot_src2_id = src2_q[issue_idx];
   assign slot_t       = t_q[issue_idx];

endmodule

// File: logic/memisq_wakeup.sv
`timescale 1ns/1ps

module memisq_wakeup #(
   parameter int MEMISQ_DEPTH = 8
) (
   input  logic                                clk,
   input  logic                                reset_n,
   input  logic                                alloc0_en,
   input  logic                                alloc1_en,
   input  logic [$clog2(MEMISQ_DEPTH)-1:0]     alloc0_idx,
   input  logic [$clog2(MEMISQ_DEPTH)-1:0]     alloc1_idx,
   input  mem_issue_pkg::prf_id_t              instr0_src1_id,
   input  mem_issue_pkg::prf_id_t              instr0_src2_id,
   input  mem_issue_pkg::prf_id_t              instr1_src1_id,
   input  mem_issue_pkg::prf_id_t              instr1_src2_id,
   input  logic                                instr0_rs1_valid,
   input  logic                                instr0_rs2_valid,
   input  logic                                instr1_rs1_valid,
   input  logic                                instr1_rs2_valid,
   input  logic                                instr0_src1_busy,
   input  logic                                instr0_src2_busy,
   input  logic                                instr1_src1_busy,
   input  logic                                instr1_src2_busy,
   input  logic [MEMISQ_DEPTH-1:0]             entry_valid,
   input  logic [mem_issue_pkg::WB_PORTS-1:0]  wb_hit,
   input  mem_issue_pkg::prf_id_t              wb_prd [mem_issue_pkg::WB_PORTS],
   output logic [MEMISQ_DEPTH-1:0]             entry_ready
);
   import mem_issue_pkg::*;

   prf_id_t                 src1_id [MEMISQ_DEPTH];
   prf_id_t                 src2_id [MEMISQ_DEPTH];
   logic [MEMISQ_DEPTH-1:0] use1;
   logic [MEMISQ_DEPTH-1:0] use2;
   logic [MEMISQ_DEPTH-1:0] pend1;   // source still waits for its producer
   logic [MEMISQ_DEPTH-1:0] pend2;
   logic [MEMISQ_DEPTH-1:0] wake1;
   logic [MEMISQ_DEPTH-1:0] wake2;

   always_comb begin
      wake1 = '0;
      wake2 = '0;
      for (int i = 0; i < MEMISQ_DEPTH; i++) begin
         for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_hit[p] && src1_id[i] == wb_prd[p])
               wake1[i] = 1'b1;
            if (wb_hit[p] && src2_id[i] == wb_prd[p])
               wake2[i] = 1'b1;
         end
      end
   end

   // slot 0 takes instr1 on a single enqueue
   always_ff @(posedge clk) begin
      if (alloc0_en) begin
         src1_id[alloc0_idx] <= alloc1_en ? instr0_src1_id : instr1_src1_id;
         src2_id[alloc0_idx] <= alloc1_en ? instr0_src2_id : instr1_src2_id;
         use1[alloc0_idx]    <= alloc1_en ? instr0_rs1_valid : instr1_rs1_valid;
         use2[alloc0_idx]    <= alloc1_en ? instr0_rs2_valid : instr1_rs2_valid;
      end
      if (alloc1_en) begin
         src1_id[alloc1_idx] <= instr1_src1_id;
         src2_id[alloc1_idx] <= instr1_src2_id;
         use1[alloc1_idx]    <= instr1_rs1_valid;
         use2[alloc1_idx]    <= instr1_rs2_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pend1 <= '0;
         pend2 <= '0;
      end else begin
         pend1 <= pend1 & ~(wake1 & entry_valid);
         pend2 <= pend2 & ~(wake2 & entry_valid);
         if (alloc0_en) begin
            pend1[alloc0_idx] <= alloc1_en ? instr0_src1_busy : instr1_src1_busy;
            pend2[alloc0_idx] <= alloc1_en ? instr0_src2_busy : instr1_src2_busy;
         end
         if (alloc1_en) begin
            pend1[alloc1_idx] <= instr1_src1_busy;
            pend2[alloc1_idx] <= instr1_src2_busy;
         end
      end
   end

   assign entry_ready = entry_valid & ~(use1 & pend1) & ~(use2 & pend2);

endmodule

// File: testbench/mem_issue_unit_sva.sv
`timescale 1ns/1ps

module mem_issue_unit_sva (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  alloc0_en,
   input  logic                  flush_valid,
   input  logic                  mem_issue_stall,
   input  logic                  slot_valid,
   input  mem_issue_pkg::left_t  memisq_left
);

   logic enq_seen;   // first enqueue since reset

   always_ff @(posedge clk) begin
      if (!reset_n)
         enq_seen <= 1'b0;
      else if (alloc0_en)
         enq_seen <= 1'b1;
   end

   no_issue_in_flush_or_stall: assert property (@(posedge clk) disable iff (!reset_n)
      slot_valid |-> !flush_valid && !mem_issue_stall)
      else $error("slot_valid high during flush or stall");

   left_code_legal: assert property (@(posedge clk) disable iff (!reset_n)
      memisq_left != 2'd3)
      else $error("memisq_left holds the unused code 3");

   no_issue_before_enqueue: assert property (@(posedge clk) disable iff (!reset_n)
      !enq_seen |-> !slot_valid)
      else $error("slot_valid high before any enqueue");

endmodule

bind memisq_ctrl mem_issue_unit_sva i_mem_issue_unit_sva (
   .clk, .reset_n, .alloc0_en, .flush_valid, .mem_issue_stall, .slot_valid, .memisq_left
);

// File: testbench/mem_issue_unit_tb.sv
`timescale 1ns/1ps

module mem_issue_unit_tb;
   import mem_issue_pkg::*;

   localparam int DEPTH      = 8;
   localparam int MAX_CYCLES = 600;   // the tests take under 100 cycles

   typedef struct packed {
      pc_t       pc;
      rob_id_t   robid;
      mem_ctrl_t ctrl;
      prf_id_t   s1;
      prf_id_t   s2;
      prf_id_t   t;
      logic      p1;   // source still pending
      logic      p2;
   } entry_t;

   logic                    clk = 1'b0;
   logic                    reset_n = 1'b0;
   logic                    instr0_enq_valid, instr1_enq_valid;
   mem_ctrl_t               instr0_control, instr1_control;
   pc_t                     instr0_pc, instr1_pc;
   rob_id_t                 instr0_robid, instr1_robid;
   prf_id_t                 instr0_src1_id, instr0_src2_id, instr1_src1_id, instr1_src2_id;
   prf_id_t                 instr0_t, instr1_t;
   logic [WB_PORTS-1:0]     wb_valid, wb_need;
   prf_id_t                 wb_prd [WB_PORTS];
   logic                    flush_valid, mem_issue_stall;
   rob_id_t                 flush_robid;
   left_t                   memisq_left;
   logic                    slot_valid;
   prf_id_t                 slot_t, slot_src1_id, slot_src2_id;
   mem_ctrl_t               slot_control;
   pc_t                     slot_pc;
   rob_id_t                 slot_robid;

   logic [2**PRF_WIDTH-1:0] busy_m;   // reference busy bits
   entry_t                  ref_q [$];
   rob_id_t                 rob_next;
   logic [31:0]             lfsr = 32'h9574;
   int                      errors = 0;
   int                      cycles = 0;

   mem_issue_unit #(.MEMISQ_DEPTH(DEPTH)) i_mem_issue_unit (
      .clk, .reset_n, .instr0_enq_valid, .instr1_enq_valid,
      .instr0_control, .instr1_control, .instr0_pc, .instr1_pc,
      .instr0_robid, .instr1_robid, .instr0_src1_id, .instr0_src2_id,
      .instr1_src1_id, .instr1_src2_id, .instr0_t, .instr1_t,
      .writeback0_valid (wb_valid[0]), .writeback0_need_to_wb (wb_need[0]),
      .writeback0_prd (wb_prd[0]),
      .writeback1_valid (wb_valid[1]), .writeback1_need_to_wb (wb_need[1]),
      .writeback1_prd (wb_prd[1]),
      .writeback2_valid (wb_valid[2]), .writeback2_need_to_wb (wb_need[2]),
      .writeback2_prd (wb_prd[2]),
      .writeback3_valid (wb_valid[3]), .writeback3_need_to_wb (wb_need[3]),
      .writeback3_prd (wb_prd[3]),
      .flush_valid, .flush_robid, .mem_issue_stall, .memisq_left, .slot_valid,
      .slot_t, .slot_src1_id, .slot_src2_id, .slot_control, .slot_pc, .slot_robid
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
         report_fail();
      end
   end

   task automatic report_fail();
      $display("tests failed");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
      $display("** Error at time %0t: %s expected 'h%0h, got 'h%0h", $time, name, exp, act);
      errors++;
      report_fail();
   endtask

   task automatic check_left(string name, left_t exp, left_t act);
      if (act !== exp)
         report_mismatch(name, 32'(exp), 32'(act));
   endtask

   task automatic check_bit(string name, logic exp, logic act);
      if (act !== exp)
         report_mismatch(name, 32'(exp), 32'(act));
   endtask

   task automatic check_prf(string name, prf_id_t exp, prf_id_t act);
      if (act !== exp)
         report_mismatch(name, 32'(exp), 32'(act));
   endtask

   task automatic check_rob(string name, rob_id_t exp, rob_id_t act);
      if (act !== exp)
         report_mismatch(name, 32'(exp), 32'(act));
   endtask

   task automatic check_pc(string name, pc_t exp, pc_t act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   task automatic check_ctrl(string name, mem_ctrl_t exp, mem_ctrl_t act);
      if (act !== exp)
         report_mismatch(name, 32'(exp), 32'(act));
   endtask

   // galois lfsr, one step per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   // sources from the low half, destinations from the high half
   function automatic entry_t free_entry();
      entry_t e;
      e = '0;
      e.pc = rand_bits(32);
      e.robid = rob_next;
      e.ctrl = 8'(rand_bits(8));
      e.s1 = {1'b0, 5'(rand_bits(5))};
      e.s2 = {1'b0, 5'(rand_bits(5))};
      e.t = {1'b1, 5'(rand_bits(5))};
      rob_next = rob_next + 1'b1;
      return e;
   endfunction

   function automatic entry_t blocked_on(prf_id_t r);
      entry_t e;
      e = free_entry();
      e.ctrl[CTRL_RS1_VALID] = 1'b1;
      e.s1 = r;
      return e;
   endfunction

   function automatic logic src_busy(prf_id_t s, logic [2**PRF_WIDTH-1:0] wb_mask);
      return busy_m[s] & ~wb_mask[s];
   endfunction

   function automatic logic is_ready(entry_t e);
      return !(e.ctrl[CTRL_RS1_VALID] && e.p1) && !(e.ctrl[CTRL_RS2_VALID] && e.p2);
   endfunction

   function automatic logic younger(rob_id_t r, rob_id_t f);
      if (r[ROB_WIDTH] == f[ROB_WIDTH])
         return r[ROB_WIDTH-1:0] > f[ROB_WIDTH-1:0];
      else
         return r[ROB_WIDTH-1:0] <= f[ROB_WIDTH-1:0];   // other side of the wrap
   endfunction

   function automatic left_t expected_left(int used);
      if (DEPTH - used >= 2)
         return 2'd2;
      else if (DEPTH - used == 1)
         return 2'd1;
      else
         return 2'd0;
   endfunction

   task automatic idle_inputs();
      instr0_enq_valid = 1'b0;
      instr1_enq_valid = 1'b0;
      wb_valid = '0;
      wb_need = '0;
      flush_valid = 1'b0;
      mem_issue_stall = 1'b0;
   endtask

   task automatic put_instr(int slot, entry_t e);
      if (slot == 0) begin
         instr0_enq_valid = 1'b1;
         instr0_pc = e.pc;
         instr0_robid = e.robid;
         instr0_control = e.ctrl;
         instr0_src1_id = e.s1;
         instr0_src2_id = e.s2;
         instr0_t = e.t;
      end else begin
         instr1_enq_valid = 1'b1;
         instr1_pc = e.pc;
         instr1_robid = e.robid;
         instr1_control = e.ctrl;
         instr1_src1_id = e.s1;
         instr1_src2_id = e.s2;
         instr1_t = e.t;
      end
   endtask

   task automatic set_wb(int port, prf_id_t prd, logic need);
      wb_valid[port] = 1'b1;
      wb_need[port] = need;
      wb_prd[port] = prd;
   endtask

   // check the current cycle at the falling edge, then step the model over the edge
   task automatic cycle();
      logic [2**PRF_WIDTH-1:0] wb_mask;
      logic                    exp_valid;
      entry_t                  e0;
      entry_t                  e1;
      entry_t                  kept [$];
      @(negedge clk);
      exp_valid = ref_q.size() > 0 && is_ready(ref_q[0]) && !flush_valid && !mem_issue_stall;
      check_left("memisq_left", expected_left(ref_q.size()), memisq_left);
      check_bit("slot_valid", exp_valid, slot_valid);
      if (exp_valid) begin
         check_pc("slot_pc", ref_q[0].pc, slot_pc);
         check_rob("slot_robid", ref_q[0].robid, slot_robid);
         check_ctrl("slot_control", ref_q[0].ctrl, slot_control);
         check_prf("slot_src1_id", ref_q[0].s1, slot_src1_id);
         check_prf("slot_src2_id", ref_q[0].s2, slot_src2_id);
         check_prf("slot_t", ref_q[0].t, slot_t);
      end
      wb_mask = '0;
      for (int p = 0; p < WB_PORTS; p++) begin
         if (wb_valid[p] && wb_need[p])
            wb_mask[wb_prd[p]] = 1'b1;
      end
      e0 = '{pc: instr0_pc, robid: instr0_robid, ctrl: instr0_control,
             s1: instr0_src1_id, s2: instr0_src2_id, t: instr0_t,
             p1: src_busy(instr0_src1_id, wb_mask), p2: src_busy(instr0_src2_id, wb_mask)};
      e1 = '{pc: instr1_pc, robid: instr1_robid, ctrl: instr1_control,
             s1: instr1_src1_id, s2: instr1_src2_id, t: instr1_t,
             p1: src_busy(instr1_src1_id, wb_mask) |
                 (instr0_enq_valid && instr1_src1_id == instr0_t),
             p2: src_busy(instr1_src2_id, wb_mask) |
                 (instr0_enq_valid && instr1_src2_id == instr0_t)};
      foreach (ref_q[i]) begin
         kept.push_back(ref_q[i]);
         if (wb_mask[ref_q[i].s1])
            kept[i].p1 = 1'b0;
         if (wb_mask[ref_q[i].s2])
            kept[i].p2 = 1'b0;
      end
      ref_q = kept;
      if (flush_valid) begin
         kept.delete();
         foreach (ref_q[i]) begin
            if (!younger(ref_q[i].robid, flush_robid))
               kept.push_back(ref_q[i]);
         end
         ref_q = kept;
      end else begin
         if (exp_valid)
            ref_q.delete(0);
         if (instr0_enq_valid && instr1_enq_valid) begin
            ref_q.push_back(e0);
            ref_q.push_back(e1);
         end else if (instr1_enq_valid) begin
            ref_q.push_back(e1);   // a lone instruction comes on instr1
         end
      end
      busy_m = busy_m & ~wb_mask;
      if (instr0_enq_valid)
         busy_m[instr0_t] = 1'b1;
      if (instr1_enq_valid)
         busy_m[instr1_t] = 1'b1;
      @(posedge clk);
      #5;
      idle_inputs();
   endtask

   task automatic drain();
      while (ref_q.size() > 0)
         cycle();
   endtask

   task automatic test_reset();
      cycle();   // empty queue, no issue, two or more free
   endtask

   task automatic test_ready_issue();
      put_instr(0, free_entry());
      put_instr(1, free_entry());
      cycle();
      put_instr(1, free_entry());
      cycle();
      put_instr(0, free_entry());
      put_instr(1, free_entry());
      cycle();
      drain();
   endtask

   task automatic test_wakeup();
      entry_t a;
      entry_t b;
      a = free_entry();
      a.t = 6'd5;
      b = blocked_on(6'd5);   // reads instr0's destination in the same group
      put_instr(0, a);
      put_instr(1, b);
      cycle();
      a = free_entry();
      a.t = 6'd7;
      put_instr(1, a);
      cycle();
      b = free_entry();
      b.ctrl[CTRL_RS2_VALID] = 1'b1;
      b.s2 = 6'd7;
      put_instr(1, b);
      cycle();
      set_wb(2, 6'd5, 1'b0);   // no register write
      cycle();
      cycle();
      set_wb(1, 6'd5, 1'b1);
      cycle();
      cycle();
      set_wb(3, 6'd7, 1'b1);
      cycle();
      drain();
   endtask

   task automatic test_stall();
      put_instr(0, free_entry());
      put_instr(1, free_entry());
      mem_issue_stall = 1'b1;
      cycle();
      for (int i = 0; i < 3; i++) begin
         mem_issue_stall = 1'b1;
         if (i == 0)
            put_instr(1, free_entry());
         cycle();
      end
      drain();
   endtask

   task automatic test_flush();
      entry_t e;
      rob_next = 6'd29;
      e = free_entry();
      e.t = 6'd9;
      put_instr(1, e);
      cycle();
      put_instr(0, blocked_on(6'd9));   // robid 30 holds the rest back
      put_instr(1, free_entry());
      cycle();
      put_instr(0, free_entry());   // robid 32, index 0 after the wrap
      put_instr(1, free_entry());
      cycle();
      put_instr(1, free_entry());
      cycle();
      flush_valid = 1'b1;
      flush_robid = 6'd32;
      cycle();
      cycle();
      set_wb(0, 6'd9, 1'b1);
      cycle();
      drain();
      cycle();   // nothing younger may come back
   endtask

   task automatic test_fill();
      entry_t e;
      e = free_entry();
      e.t = 6'd11;
      put_instr(1, e);
      cycle();
      while (ref_q.size() < DEPTH) begin
         if (DEPTH - ref_q.size() > 2) begin
            put_instr(0, blocked_on(6'd11));
            put_instr(1, blocked_on(6'd11));
         end else begin
            put_instr(1, blocked_on(6'd11));
         end
         cycle();
      end
      cycle();   // full
      set_wb(2, 6'd11, 1'b1);
      cycle();
      drain();
      cycle();
   endtask

   initial begin
      for (int p = 0; p < WB_PORTS; p++)
         wb_prd[p] = '0;
      flush_robid = '0;
      busy_m = '0;
      rob_next = '0;
      put_instr(0, '0);
      put_instr(1, '0);
      idle_inputs();
      repeat (4) @(posedge clk);
      #5;
      reset_n = 1'b1;
      test_reset();
      test_ready_issue();
      test_wakeup();
      test_stall();
      test_flush();
      test_fill();
      if (errors == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         report_fail();
      end
   end

endmodule
